/* source/iso_align_pkg.sv */
// shared widths, limits and vector types for the write-channel alignment block
// sized for full AXI4 bursts (AWLEN up to 255) and a skew of two maximum bursts
// changing max_transaction_skew also changes the AWLEN FIFO depth
`default_nettype none

package iso_align_pkg;

  // AWLEN as carried on the AW channel, zero-based
  localparam int axi_len_width = 8;

  // number of beats in the longest legal burst
  localparam int max_burst_beats = 2 ** axi_len_width;

  // how many maximum-length bursts may be owed before AW is back-pressured
  // this is also the number of AWLEN entries kept for wlast generation
  localparam int max_transaction_skew = 2;

  // upper bound on the owed-beat counter
  localparam int max_pending_beats = max_transaction_skew * max_burst_beats;

  // at or above this level another maximum burst might not fit, so AW is held off
  localparam int pending_full_level = max_pending_beats - max_burst_beats;

  localparam int beat_count_width = $clog2(max_burst_beats + 1);
  localparam int pending_width = $clog2(max_pending_beats + 1);
  localparam int fifo_count_width = $clog2(max_transaction_skew + 1);

  // zero-based burst length, straight from AWLEN
  typedef logic [axi_len_width-1:0] burst_len_t;

  // one-based beat count of a single burst, so 256 must fit
  typedef logic [beat_count_width-1:0] beat_count_t;

  // W beats still owed by forwarded AW requests
  typedef logic [pending_width-1:0] pending_t;

  // occupancy of the AWLEN FIFO, 0 through max_transaction_skew
  typedef logic [fifo_count_width-1:0] fifo_count_t;

endpackage

`default_nettype wire

/* source/beat_tracker.sv */
// counts W beats owed by AW requests already sent downstream
// relies on the control logic never letting W run ahead of AW, so no underflow check
// full is flagged early, leaving room for one more maximum-length burst
`default_nettype none

module beat_tracker (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      aw_beat,
  input  iso_align_pkg::burst_len_t awlen,
  input  logic                      w_beat,
  output logic                      pending_full,
  output logic                      pending_zero
);

  import iso_align_pkg::*;

  // registered owed-beat count
  pending_t    pending;
  // beats added this cycle by an AW transfer, one-based
  beat_count_t aw_incr;
  pending_t    pending_next;

  // AWLEN is zero-based, so an accepted request owes awlen plus one beats
  assign aw_incr = aw_beat ? (beat_count_t'(awlen) + beat_count_t'(1)) : '0;

  // an AW and a W beat may transfer in the same cycle
  // the W beat may even belong to that same AW, the sum still works out
  assign pending_next = pending + pending_t'(aw_incr) - pending_t'(w_beat);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= '0;
    end else begin
      pending <= pending_next;
    end
  end

  // AW is held off once the next maximum burst might overflow the counter
  assign pending_full = (pending >= pending_t'(pending_full_level));

  // nothing owed means W has no request to go with, and alignment is reached
  assign pending_zero = (pending == '0);

endmodule

`default_nettype wire

/* source/awlen_fifo.sv */
// flop FIFO holding the AWLEN of each forwarded request until its last W beat
// bypasses when empty so a W beat that goes with its own AW sees the right length
// depth is max_transaction_skew, push_ready drops only when every slot is used
`default_nettype none

module awlen_fifo (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      push,
  input  iso_align_pkg::burst_len_t push_len,
  input  logic                      pop,
  output logic                      push_ready,
  output iso_align_pkg::burst_len_t head_len
);

  import iso_align_pkg::*;

  // read and write pointers index the circular storage
  typedef logic [$clog2(max_transaction_skew)-1:0] ptr_t;

  burst_len_t  mem [max_transaction_skew];
  ptr_t        rd_ptr;
  ptr_t        wr_ptr;
  fifo_count_t count;
  logic        empty;
  logic        bypass;
  logic        do_write;
  logic        do_read;

  assign empty = (count == '0);

  // a push and a pop into an empty FIFO is a burst that starts and ends
  // in the same cycle, the entry never needs to be stored
  assign bypass = empty && push && pop;

  assign do_write = push && !bypass;
  assign do_read  = pop && !empty;

  // head shows the incoming length while empty
  assign head_len = empty ? push_len : mem[rd_ptr];

  assign push_ready = (count < fifo_count_t'(max_transaction_skew));

  // storage holds payload only and needs no reset
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr] <= push_len;
    end
  end

  // pointers wrap explicitly, so the depth need not be a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (do_write) begin
      if (wr_ptr == ptr_t'(max_transaction_skew - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + ptr_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (do_read) begin
      if (rd_ptr == ptr_t'(max_transaction_skew - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + ptr_t'(1);
      end
    end
  end

  // occupancy follows the stored entries only, bypassed ones never count
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      count <= count + fifo_count_t'(do_write) - fifo_count_t'(do_read);
    end
  end

endmodule

`default_nettype wire

/* source/wlast_gen.sv */
// generates downstream wlast from the AWLEN at the FIFO head
// the beat index restarts after every last beat, real or fake
`default_nettype none

module wlast_gen (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      w_beat,
  input  iso_align_pkg::burst_len_t head_len,
  output logic                      wlast,
  output logic                      burst_done
);

  import iso_align_pkg::*;

  // zero-based index of the next W beat within the current burst
  burst_len_t beat_idx;

  // the last beat has an index equal to the zero-based length
  assign wlast = (beat_idx == head_len);

  // a last beat that actually transfers finishes the burst and pops its length
  assign burst_done = w_beat && wlast;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_idx <= '0;
    end else if (burst_done) begin
      beat_idx <= '0;
    end else if (w_beat) begin
      beat_idx <= beat_idx + burst_len_t'(1);
    end
  end

endmodule

`default_nettype wire

/* source/align_ctrl.sv */
// handshake gating for the AW and W channels, purely combinational
// W never goes downstream without an owed beat or an AW in the same cycle
// align_req must stay high until align_done, upstream is blocked the whole time
`default_nettype none

module align_ctrl (
  input  logic upstream_awvalid,
  input  logic upstream_wvalid,
  input  logic downstream_awready,
  input  logic downstream_wready,
  input  logic align_req,
  input  logic pending_full,
  input  logic pending_zero,
  input  logic fifo_ready,
  output logic upstream_awready,
  output logic upstream_wready,
  output logic downstream_awvalid,
  output logic downstream_wvalid,
  output logic aw_beat,
  output logic w_beat,
  output logic align_done
);

  logic holdoff_aw;
  logic holdoff_w;

  // no new requests while the budget or the AWLEN FIFO is used up,
  // and none at all once alignment has been requested
  assign holdoff_aw = pending_full || !fifo_ready || align_req;

  // W needs an owed beat, or its AW going down in this very cycle
  // after alignment completes, W is frozen as well
  assign holdoff_w = align_done || (pending_zero && !aw_beat);

  assign downstream_awvalid = upstream_awvalid && !holdoff_aw;
  assign aw_beat = downstream_awvalid && downstream_awready;

  // during alignment the block itself supplies the W beats still owed
  assign downstream_wvalid = (upstream_wvalid || align_req) && !holdoff_w;
  assign w_beat = downstream_wvalid && downstream_wready;

  // readies pass straight back, so downstream stalls reach upstream at once
  // align_req already sits in holdoff_aw
  assign upstream_awready = downstream_awready && !holdoff_aw;

  // fake beats are never acknowledged upstream
  assign upstream_wready = downstream_wready && !holdoff_w && !align_req;

  // done as soon as nothing is owed
  assign align_done = align_req && pending_zero;

endmodule

`default_nettype wire

/* source/iso_wdata_align.sv */
// write-channel alignment for an AXI isolator, AW and W pass straight through
// downstream wlast is always generated here, upstream wlast is not used
// W data without a forwarded AW is never sent, excess data is not supported
// align_req may rise only while align_done is low and must hold until done
`default_nettype none

module iso_wdata_align (
  input  logic                      clk,
  input  logic                      rst_n,
  // upstream manager side
  input  logic                      upstream_awvalid,
  input  iso_align_pkg::burst_len_t upstream_awlen,
  output logic                      upstream_awready,
  input  logic                      upstream_wvalid,
  output logic                      upstream_wready,
  // downstream subordinate side
  output logic                      downstream_awvalid,
  input  logic                      downstream_awready,
  output logic                      downstream_wvalid,
  output logic                      downstream_wlast,
  input  logic                      downstream_wready,
  // isolation control
  input  logic                      align_req,
  output logic                      align_done
);

  import iso_align_pkg::*;

  // downstream transfers, as seen by the trackers
  logic       aw_beat;
  logic       w_beat;
  logic       pending_full;
  logic       pending_zero;
  logic       fifo_ready;
  burst_len_t head_len;
  logic       burst_done;

  // owed-beat count from forwarded AW and sent W
  beat_tracker i_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .aw_beat      (aw_beat),
    .awlen        (upstream_awlen),
    .w_beat       (w_beat),
    .pending_full (pending_full),
    .pending_zero (pending_zero)
  );

  // lengths of forwarded requests, popped when their last beat leaves
  awlen_fifo i_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (aw_beat),
    .push_len   (upstream_awlen),
    .pop        (burst_done),
    .push_ready (fifo_ready),
    .head_len   (head_len)
  );

  // wlast for both real and fake beats
  wlast_gen i_wlast (
    .clk        (clk),
    .rst_n      (rst_n),
    .w_beat     (w_beat),
    .head_len   (head_len),
    .wlast      (downstream_wlast),
    .burst_done (burst_done)
  );

  align_ctrl i_ctrl (
    .upstream_awvalid   (upstream_awvalid),
    .upstream_wvalid    (upstream_wvalid),
    .downstream_awready (downstream_awready),
    .downstream_wready  (downstream_wready),
    .align_req          (align_req),
    .pending_full       (pending_full),
    .pending_zero       (pending_zero),
    .fifo_ready         (fifo_ready),
    .upstream_awready   (upstream_awready),
    .upstream_wready    (upstream_wready),
    .downstream_awvalid (downstream_awvalid),
    .downstream_wvalid  (downstream_wvalid),
    .aw_beat            (aw_beat),
    .w_beat             (w_beat),
    .align_done         (align_done)
  );

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
// clock and reset for the testbench, period of 40 time units
// rst_n is held low for 8 cycles and released on a falling edge
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // release away from the rising edge so the first sampled cycle is clean
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* verification/iso_wdata_align_assert.sv */
// protocol properties of the write-channel alignment block
// bound into iso_wdata_align, keeps its own count of open bursts from the ports
`default_nettype none

module iso_wdata_align_assert (
  input logic clk,
  input logic rst_n,
  input logic downstream_awvalid,
  input logic downstream_awready,
  input logic downstream_wvalid,
  input logic downstream_wready,
  input logic downstream_wlast,
  input logic align_req,
  input logic align_done,
  input logic upstream_awready,
  input logic upstream_wready
);

  logic aw_xfer;
  logic last_xfer;
  // bursts forwarded on AW whose last W beat has not left yet
  int   open_bursts;

  assign aw_xfer   = downstream_awvalid && downstream_awready;
  assign last_xfer = downstream_wvalid && downstream_wready && downstream_wlast;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      open_bursts <= 0;
    end else begin
      open_bursts <= open_bursts + int'(aw_xfer) - int'(last_xfer);
    end
  end

  // a W beat needs a burst at the FIFO head, either open or arriving now
  a_wvalid_has_head: assert property (@(posedge clk) disable iff (!rst_n)
    downstream_wvalid |-> (open_bursts != 0 || aw_xfer))
    else $error("downstream W valid with no burst at the FIFO head");

  // upstream is fully blocked during alignment
  a_req_blocks_upstream: assert property (@(posedge clk) disable iff (!rst_n)
    align_req |-> (!upstream_awready && !upstream_wready))
    else $error("upstream ready high while align_req is set");

  // once reached, alignment holds for as long as the request stays
  a_done_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (align_req && align_done) |=> (align_done || !align_req))
    else $error("align_done dropped while align_req was still high");

  // the request may only be withdrawn once alignment was reported
  a_req_falls_after_done: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(align_req) |-> $past(align_done))
    else $error("align_req fell before align_done was seen");

  a_done_means_zero: assert property (@(posedge clk) disable iff (!rst_n)
    align_done |-> (open_bursts == 0))
    else $error("align_done high while bursts are still open");

endmodule

`default_nettype wire

/* verification/tb_iso_wdata_align.sv */
// testbench for iso_wdata_align, cases come from verification/align_cases.txt
// run from the project root, inputs change on the falling edge only
// a monitor models wlast from the forwarded AWLEN values and counts W transfers
`default_nettype none

module tb_iso_wdata_align;

  import iso_align_pkg::*;

  // cycle limits for every wait loop
  localparam int reset_timeout = 20;
  localparam int burst_timeout = 5000;
  localparam int align_timeout = 5000;
  localparam int offer_cycles = 8;

  logic       clk;
  logic       rst_n;
  logic       upstream_awvalid;
  burst_len_t upstream_awlen;
  logic       upstream_awready;
  logic       upstream_wvalid;
  logic       upstream_wready;
  logic       downstream_awvalid;
  logic       downstream_awready;
  logic       downstream_wvalid;
  logic       downstream_wlast;
  logic       downstream_wready;
  logic       align_req;
  logic       align_done;

  // monitor state, read by the stimulus only on falling edges
  burst_len_t len_q[$];
  int         beat_idx;
  int         w_count;
  int         wlast_count;

  int         seed;
  int         fd;
  int         got;
  int         lens[4];
  string      line;
  string      fields[$];
  string      cur_name;

  tb_clock i_clock (
    .clk   (clk),
    .rst_n (rst_n)
  );

  iso_wdata_align i_iso_wdata_align (
    .clk                (clk),
    .rst_n              (rst_n),
    .upstream_awvalid   (upstream_awvalid),
    .upstream_awlen     (upstream_awlen),
    .upstream_awready   (upstream_awready),
    .upstream_wvalid    (upstream_wvalid),
    .upstream_wready    (upstream_wready),
    .downstream_awvalid (downstream_awvalid),
    .downstream_awready (downstream_awready),
    .downstream_wvalid  (downstream_wvalid),
    .downstream_wlast   (downstream_wlast),
    .downstream_wready  (downstream_wready),
    .align_req          (align_req),
    .align_done         (align_done)
  );

  bind iso_wdata_align iso_wdata_align_assert i_assert (
    .clk                (clk),
    .rst_n              (rst_n),
    .downstream_awvalid (downstream_awvalid),
    .downstream_awready (downstream_awready),
    .downstream_wvalid  (downstream_wvalid),
    .downstream_wready  (downstream_wready),
    .downstream_wlast   (downstream_wlast),
    .align_req          (align_req),
    .align_done         (align_done),
    .upstream_awready   (upstream_awready),
    .upstream_wready    (upstream_wready)
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_len(input string name, input burst_len_t expected,
                           input burst_len_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input pending_t expected,
                             input pending_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s expected %0d actual %0d", name, expected, actual));
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("error: %s expected %0b actual %0b", name, expected, actual));
    end
  endtask

  // every downstream AW queues its length, the last beat of each burst
  // is the one whose index within the burst equals that length
  always @(posedge clk) begin
    if (rst_n) begin
      if (downstream_awvalid && downstream_awready) begin
        len_q.push_back(upstream_awlen);
      end
      if (downstream_wvalid && downstream_wready) begin
        if (len_q.size() == 0) begin
          abort_run("a W beat went downstream ahead of its AW request");
        end
        // the beat whose index equals AWLEN must carry wlast
        if (beat_idx == int'(len_q[0])) begin
          check_bit(cur_name, 1'b1, downstream_wlast);
        end
        w_count++;
        if (downstream_wlast) begin
          // an early wlast would close the burst short of its AWLEN
          check_len(cur_name, len_q[0], burst_len_t'(beat_idx));
          wlast_count++;
          beat_idx = 0;
          void'(len_q.pop_front());
        end else begin
          beat_idx++;
        end
      end
    end
  end

  task automatic wait_for_reset();
    int cycles;
    cycles = 0;
    while (!rst_n) begin
      @(negedge clk);
      cycles++;
      if (cycles > reset_timeout) begin
        abort_run("reset was never released");
      end
    end
  endtask

  // downstream readies are either random or held high
  task automatic drive_readies(input logic stall);
    if (stall) begin
      downstream_awready = (($random(seed) & 1) != 0);
      downstream_wready = (($random(seed) & 1) != 0);
    end else begin
      downstream_awready = 1'b1;
      downstream_wready = 1'b1;
    end
  endtask

  // splits a line on blanks into the fields queue
  task automatic split_line(input string text);
    int  start;
    byte c;
    fields.delete();
    start = -1;
    for (int i = 0; i <= text.len(); i++) begin
      c = (i < text.len()) ? text.getc(i) : " ";
      if (c == " " || c == 8'h09 || c == 8'h0a || c == 8'h0d) begin
        if (start >= 0) begin
          fields.push_back(text.substr(start, i - 1));
        end
        start = -1;
      end else if (start < 0) begin
        start = i;
      end
    end
  endtask

  // one burst through both channels, W offered from the first cycle on
  task automatic run_burst(input burst_len_t len, input logic stall);
    int   beats_left;
    int   cycles;
    int   w_start;
    int   last_start;
    logic aw_done;
    w_start = w_count;
    last_start = wlast_count;
    beats_left = int'(len) + 1;
    aw_done = 1'b0;
    cycles = 0;
    while (!aw_done || beats_left > 0) begin
      @(negedge clk);
      upstream_awvalid = !aw_done;
      upstream_awlen = len;
      upstream_wvalid = (beats_left > 0);
      drive_readies(stall);
      @(posedge clk);
      if (upstream_awvalid && upstream_awready) begin
        aw_done = 1'b1;
      end
      if (upstream_wvalid && upstream_wready) begin
        beats_left--;
      end
      cycles++;
      if (cycles > burst_timeout) begin
        abort_run($sformatf("burst in %s did not complete", cur_name));
      end
    end
    @(negedge clk);
    upstream_awvalid = 1'b0;
    upstream_wvalid = 1'b0;
    drive_readies(1'b0);
    check_count(cur_name, pending_t'(int'(len) + 1), pending_t'(w_count - w_start));
    check_count(cur_name, pending_t'(1), pending_t'(wlast_count - last_start));
  endtask

  // offers one AW for a few cycles and reports whether it was taken
  task automatic offer_aw(input burst_len_t len, input logic expect_taken,
                          output logic accepted);
    int cycles;
    accepted = 1'b0;
    cycles = 0;
    @(negedge clk);
    upstream_awvalid = 1'b1;
    upstream_awlen = len;
    while (!accepted && cycles < offer_cycles) begin
      @(posedge clk);
      // with awready held high, AW shows downstream only when it fits
      check_bit(cur_name, expect_taken, downstream_awvalid);
      accepted = upstream_awready;
      cycles++;
    end
    @(negedge clk);
    upstream_awvalid = 1'b0;
  endtask

  // AWs only, with W stalled downstream, against the budget model
  task automatic offer_bursts(input int count, output int accepted_n, output int owed);
    int   entries;
    logic fits;
    logic accepted;
    accepted_n = 0;
    owed = 0;
    entries = 0;
    @(negedge clk);
    downstream_awready = 1'b1;
    downstream_wready = 1'b0;
    upstream_wvalid = 1'b0;
    for (int i = 0; i < count; i++) begin
      // room is needed for one more maximum burst and a FIFO slot
      fits = (owed < pending_full_level) && (entries < max_transaction_skew);
      offer_aw(burst_len_t'(lens[i]), fits, accepted);
      check_bit(cur_name, fits, accepted);
      if (fits) begin
        owed += lens[i] + 1;
        entries++;
      end
      if (accepted) begin
        accepted_n++;
      end
    end
  endtask

  // the block itself sends the owed beats as fake W data
  task automatic run_alignment(input int owed, input logic stall);
    int   start;
    int   cycles;
    logic done_seen;
    start = w_count;
    cycles = 0;
    done_seen = 1'b0;
    @(negedge clk);
    upstream_awvalid = 1'b0;
    upstream_wvalid = 1'b0;
    align_req = 1'b1;
    drive_readies(stall);
    while (!done_seen) begin
      @(posedge clk);
      check_bit(cur_name, 1'b0, upstream_awready);
      check_bit(cur_name, 1'b0, upstream_wready);
      done_seen = align_done;
      cycles++;
      if (!done_seen && cycles > align_timeout) begin
        abort_run($sformatf("align_done never rose in %s", cur_name));
      end
      @(negedge clk);
      drive_readies(stall);
    end
    check_count(cur_name, pending_t'(owed), pending_t'(w_count - start));
    // done stays up as long as the request does
    repeat (3) begin
      @(posedge clk);
      check_bit(cur_name, 1'b1, align_done);
    end
    @(negedge clk);
    align_req = 1'b0;
    drive_readies(1'b0);
    @(posedge clk);
    check_bit(cur_name, 1'b0, align_done);
  endtask

  task automatic run_case(input string kind, input logic stall, input int count,
                          input int expected);
    int         total;
    int         accepted_n;
    int         owed;
    int         w_start;
    burst_len_t len;
    total = 0;
    if (kind != "random" && count > 4) begin
      abort_run($sformatf("case %s lists more than four bursts", cur_name));
    end
    if (kind == "pass") begin
      w_start = w_count;
      for (int i = 0; i < count; i++) begin
        run_burst(burst_len_t'(lens[i]), stall);
      end
      check_count(cur_name, pending_t'(expected), pending_t'(w_count - w_start));
    end else if (kind == "noearly") begin
      @(negedge clk);
      upstream_wvalid = 1'b1;
      repeat (20) begin
        @(posedge clk);
        check_bit(cur_name, 1'b0, downstream_wvalid);
      end
      @(negedge clk);
      upstream_wvalid = 1'b0;
    end else if (kind == "budget") begin
      offer_bursts(count, accepted_n, owed);
      check_count(cur_name, pending_t'(expected), pending_t'(accepted_n));
      run_alignment(owed, 1'b0);
    end else if (kind == "align") begin
      offer_bursts(count, accepted_n, owed);
      check_count(cur_name, pending_t'(count), pending_t'(accepted_n));
      run_alignment(expected, stall);
      run_burst(burst_len_t'(2), stall);
    end else if (kind == "random") begin
      // lens[0] is the longest random length, totals cover all bursts
      accepted_n = wlast_count;
      owed = w_count;
      for (int i = 0; i < count; i++) begin
        len = burst_len_t'($unsigned($random(seed)) % (lens[0] + 1));
        run_burst(len, stall);
        total += int'(len) + 1;
      end
      check_count(cur_name, pending_t'(total), pending_t'(w_count - owed));
      check_count(cur_name, pending_t'(count), pending_t'(wlast_count - accepted_n));
    end else begin
      abort_run({"unknown case kind: ", kind});
    end
  endtask

  initial begin
    upstream_awvalid = 1'b0;
    upstream_awlen = '0;
    upstream_wvalid = 1'b0;
    downstream_awready = 1'b1;
    downstream_wready = 1'b1;
    align_req = 1'b0;
    beat_idx = 0;
    w_count = 0;
    wlast_count = 0;
    cur_name = "reset";
    seed = 83;
    wait_for_reset();
    fd = $fopen("verification/align_cases.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open verification/align_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      got = $fgets(line, fd);
      split_line(line);
      if (got == 0 || fields.size() == 0) begin
        continue;
      end
      if (fields[0].getc(0) == "#") begin
        continue;
      end
      if (fields.size() != 9) begin
        abort_run({"malformed case line: ", line});
      end
      cur_name = fields[0];
      for (int i = 0; i < 4; i++) begin
        lens[i] = fields[4 + i].atoi();
      end
      run_case(fields[1], fields[2].atoi() != 0, fields[3].atoi(), fields[8].atoi());
    end
    $fclose(fd);
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/align_cases.txt */
# columns: name kind stall count len0 len1 len2 len3 expected
# expected is total W beats (pass), accepted AWs (budget), owed beats (align), 0 otherwise
single_beat    pass     0  1  0    0    0    0  1
short_burst    pass     0  1  3    0    0    0  4
mixed_bursts   pass     1  4  7    0    255  1  267
no_early_data  noearly  0  0  0    0    0    0  0
budget_max     budget   0  3  255  255  255  0  1
budget_fifo    budget   0  4  3    3    3    3  2
budget_mixed   budget   0  3  100  200  50   0  2
align_two      align    0  2  3    9    0    0  14
align_stall    align    1  1  200  0    0    0  201
random_mix     random   1  40 15   0    0    0  0

/* build.f */
source/iso_align_pkg.sv
source/beat_tracker.sv
source/awlen_fifo.sv
source/wlast_gen.sv
source/align_ctrl.sv
source/iso_wdata_align.sv
verification/tb_clock.sv
verification/iso_wdata_align_assert.sv
verification/tb_iso_wdata_align.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
# the exit status of the simulation is the pass or fail result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module tb_iso_wdata_align -o sim_tb
./obj_dir/sim_tb
